/* all.f */
devinfo_pkg.sv
boot_delay.sv
dna_port_model.sv
dna_reader.sv
icap_model.sv
icap_idcode_reader.sv
devinfo_apb.sv
device_info_top.sv
tb_device_info.sv

/* boot_delay.sv */
`timescale 1ns/10ps

module boot_delay #(
	parameter logic [23:0] BOOT_CYCLES = 24'd1000
) (
	input  logic clk,
	input  logic rst_n,
	output logic boot_done
);

	// cycles elapsed since reset release
	logic [23:0] boot_cnt;

	////////////////////
	// hold-off counter

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			boot_cnt  <= 24'd0;
			boot_done <= 1'b0;
		end else if (!boot_done) begin
			// counter freezes once done is set
			if (boot_cnt == BOOT_CYCLES) begin
				boot_done <= 1'b1;
			end else begin
				boot_cnt <= boot_cnt + 24'd1;
			end
		end
	end

	// done stays high until the next reset
	// both readers wait on this one flag

endmodule

/* device_info_top.sv */
`timescale 1ns/10ps

module device_info_top #(
	parameter logic [23:0]                      BOOT_CYCLES  = 24'd1000,
	parameter logic [devinfo_pkg::DNA_BITS-1:0] DNA_VALUE    = '0,
	parameter logic [31:0]                      IDCODE_VALUE = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	// shared power-up hold-off
	logic        boot_done;
	// identity values toward the register block
	logic [63:0] die_serial;
	logic        die_serial_valid;
	logic [31:0] idcode;
	logic        idcode_valid;

	boot_delay #(
		.BOOT_CYCLES(BOOT_CYCLES)
	) u_boot (
		.clk      (clk),
		.rst_n    (rst_n),
		.boot_done(boot_done)
	);

	dna_reader #(
		.DNA_VALUE(DNA_VALUE)
	) u_dna (
		.clk             (clk),
		.rst_n           (rst_n),
		.boot_done       (boot_done),
		.die_serial      (die_serial),
		.die_serial_valid(die_serial_valid)
	);

	icap_idcode_reader #(
		.IDCODE_VALUE(IDCODE_VALUE)
	) u_icap (
		.clk         (clk),
		.rst_n       (rst_n),
		.boot_done   (boot_done),
		.idcode      (idcode),
		.idcode_valid(idcode_valid)
	);

	devinfo_apb u_apb (
		.clk             (clk),
		.rst_n           (rst_n),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.die_serial      (die_serial),
		.die_serial_valid(die_serial_valid),
		.idcode          (idcode),
		.idcode_valid    (idcode_valid)
	);

endmodule

/* devinfo_apb.sv */
`timescale 1ns/10ps

module devinfo_apb (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic [63:0] die_serial,
	input  logic        die_serial_valid,
	input  logic [31:0] idcode,
	input  logic        idcode_valid
);

	import devinfo_pkg::*;

	logic        setup;
	logic        mapped;
	logic [31:0] rd_word;

	// setup phase, response registered for the access phase
	assign setup = psel && !penable;

	////////////////////
	// address decode

	always_comb begin
		mapped = 1'b1;
		case (paddr)
			REG_STATUS:    rd_word = {30'd0, idcode_valid, die_serial_valid};
			// serial shifts in place, hide it until complete
			REG_SERIAL_LO: rd_word = die_serial_valid ? die_serial[31:0] : 32'd0;
			REG_SERIAL_HI: rd_word = die_serial_valid ? die_serial[63:32] : 32'd0;
			REG_IDCODE:    rd_word = idcode_valid ? idcode : 32'd0;
			default: begin
				rd_word = 32'd0;
				mapped  = 1'b0;
			end
		endcase
	end

	////////////////////
	// response, no wait states

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prdata  <= 32'd0;
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready <= setup;
			if (setup) begin
				// rejected write data shows on prdata, for bus traces
				prdata  <= pwrite ? pwdata : rd_word;
				pslverr <= pwrite || !mapped;
			end
		end
	end

endmodule

/* devinfo_pkg.sv */
package devinfo_pkg;

	////////////////////
	// die identity widths and port timing

	// 57-bit die serial, padded to 64 on the register side
	localparam int DNA_BITS = 57;
	// read select to valid dout on the config port
	localparam int ICAP_READ_LATENCY = 3;

	////////////////////
	// reader state machines

	typedef enum logic [1:0] {
		DNA_BOOT = 2'h0,
		DNA_READ = 2'h1,
		DNA_DONE = 2'h2
	} dna_state_t;

	typedef enum logic [2:0] {
		ICAP_BOOT_HOLD = 3'h0,
		ICAP_SYNC      = 3'h1,
		ICAP_NOP       = 3'h2,
		ICAP_HEADER    = 3'h3,
		ICAP_PIPE      = 3'h4,
		ICAP_READ      = 3'h5,
		ICAP_DONE      = 3'h6
	} icap_state_t;

	////////////////////
	// config port command words, in bitstream order

	typedef enum logic [31:0] {
		OP_SYNC            = 32'haa995566,
		OP_NOP             = 32'h20000000,
		// type 1 read, IDCODE register, one word
		OP_READ_IDCODE_HDR = 32'h28018001,
		// type 1 write, CMD register, one word
		OP_WRITE_CMD_HDR   = 32'h30008001,
		OP_DESYNC_CMD      = 32'h0000000d
	} icap_op_t;

	////////////////////
	// APB register map, byte offsets

	localparam logic [11:0] REG_STATUS    = 12'h000;
	localparam logic [11:0] REG_SERIAL_LO = 12'h004;
	localparam logic [11:0] REG_SERIAL_HI = 12'h008;
	localparam logic [11:0] REG_IDCODE    = 12'h00c;

	// the config port wants every byte bit-reversed, both directions
	function automatic logic [31:0] byte_bitswap(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++) begin
			for (int i = 0; i < 8; i++) begin
				r[b*8 + i] = w[b*8 + 7 - i];
			end
		end
		return r;
	endfunction

endpackage

/* dna_port_model.sv */
`timescale 1ns/10ps

module dna_port_model #(
	parameter logic [devinfo_pkg::DNA_BITS-1:0] DNA_VALUE = '0
) (
	input  logic clk,
	input  logic read,
	input  logic shift,
	output logic dout
);

	import devinfo_pkg::*;

	// stand-in for the die DNA primitive
	// value is fused in silicon, here it comes from the parameter

	// shift register holding the serial
	logic [DNA_BITS-1:0] dna_sr;

	////////////////////
	// load and shift

	always_ff @(posedge clk) begin
		// read wins over shift, as on the real port
		if (read) begin
			dna_sr <= DNA_VALUE;
		end else if (shift) begin
			// MSB leaves first, zeros fill from the bottom
			dna_sr <= {dna_sr[DNA_BITS-2:0], 1'b0};
		end
	end

	// top bit is always on the pin
	// valid from the cycle after read
	assign dout = dna_sr[DNA_BITS-1];

endmodule

/* dna_reader.sv */
`timescale 1ns/10ps

module dna_reader #(
	parameter logic [devinfo_pkg::DNA_BITS-1:0] DNA_VALUE = '0
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        boot_done,
	output logic [63:0] die_serial,
	output logic        die_serial_valid
);

	import devinfo_pkg::*;

	// count reaches this on the last capture
	localparam logic [6:0] BIT_LAST = 7'(DNA_BITS);

	dna_state_t state;
	logic [6:0] bit_cnt;
	logic       dna_read;
	logic       dna_shift;
	logic       dna_dout;

	dna_port_model #(
		.DNA_VALUE(DNA_VALUE)
	) dna_port (
		.clk  (clk),
		.read (dna_read),
		.shift(dna_shift),
		.dout (dna_dout)
	);

	////////////////////
	// read sequence

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state            <= DNA_BOOT;
			bit_cnt          <= 7'd0;
			dna_read         <= 1'b0;
			dna_shift        <= 1'b0;
			die_serial       <= 64'd0;
			die_serial_valid <= 1'b0;
		end else begin
			// strobes are single cycle
			dna_read  <= 1'b0;
			dna_shift <= 1'b0;
			case (state)
				DNA_BOOT: begin
					if (boot_done) begin
						dna_read <= 1'b1;
						bit_cnt  <= 7'd0;
						state    <= DNA_READ;
					end
				end
				DNA_READ: begin
					bit_cnt <= bit_cnt + 7'd1;
					if (bit_cnt < BIT_LAST) begin
						dna_shift <= 1'b1;
					end
					// first cycle is the load, nothing on dout yet
					if (bit_cnt != 7'd0) begin
						die_serial <= {{(64-DNA_BITS){1'b0}},
							die_serial[DNA_BITS-2:0], dna_dout};
					end
					if (bit_cnt == BIT_LAST) begin
						die_serial_valid <= 1'b1;
						state            <= DNA_DONE;
					end
				end
				// done, serial held until reset
				default: begin
				end
			endcase
		end
	end

endmodule

/* icap_idcode_reader.sv */
`timescale 1ns/10ps

module icap_idcode_reader #(
	parameter logic [31:0] IDCODE_VALUE = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        boot_done,
	output logic [31:0] idcode,
	output logic        idcode_valid
);

	import devinfo_pkg::*;

	localparam logic [3:0] LAT = 4'(ICAP_READ_LATENCY);

	icap_state_t state;
	// shared step counter for nops, turnaround, read and desync
	logic [3:0]  step;
	logic        icap_cs_n;
	logic        icap_wr_n;
	logic [31:0] icap_din;
	logic [31:0] icap_dout;

	icap_model #(
		.IDCODE_VALUE(IDCODE_VALUE)
	) icap (
		.clk  (clk),
		.rst_n(rst_n),
		.cs_n (icap_cs_n),
		.wr_n (icap_wr_n),
		.din  (icap_din),
		.dout (icap_dout)
	);

	////////////////////
	// command sequence

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= ICAP_BOOT_HOLD;
			step         <= 4'd0;
			icap_cs_n    <= 1'b1;
			icap_wr_n    <= 1'b1;
			icap_din     <= '1;
			idcode       <= 32'd0;
			idcode_valid <= 1'b0;
		end else begin
			case (state)
				ICAP_BOOT_HOLD: begin
					// select in write mode, first word is a dummy
					if (boot_done) begin
						icap_cs_n <= 1'b0;
						icap_wr_n <= 1'b0;
						state     <= ICAP_SYNC;
					end
				end
				ICAP_SYNC: begin
					icap_din <= byte_bitswap(OP_SYNC);
					step     <= 4'd0;
					state    <= ICAP_NOP;
				end
				// two hazard slots after sync
				ICAP_NOP: begin
					icap_din <= byte_bitswap(OP_NOP);
					step     <= step + 4'd1;
					if (step == 4'd1) begin
						state <= ICAP_HEADER;
					end
				end
				ICAP_HEADER: begin
					icap_din <= byte_bitswap(OP_READ_IDCODE_HDR);
					step     <= 4'd0;
					state    <= ICAP_PIPE;
				end
				// flush nop, then deselect, flip to read, reselect
				ICAP_PIPE: begin
					icap_din <= byte_bitswap(OP_NOP);
					step     <= step + 4'd1;
					if (step == 4'd1) begin
						icap_cs_n <= 1'b1;
					end
					if (step == 4'd2) begin
						icap_wr_n <= 1'b1;
					end
					if (step == 4'd3) begin
						icap_cs_n <= 1'b0;
						step      <= 4'd0;
						state     <= ICAP_READ;
					end
				end
				// wait out the port latency, then grab the word
				ICAP_READ: begin
					step <= step + 4'd1;
					if (step == LAT) begin
						idcode       <= byte_bitswap(icap_dout);
						idcode_valid <= 1'b1;
						step         <= 4'd0;
						state        <= ICAP_DONE;
					end
				end
				// desync so the port is left free, idcode untouched
				default: begin
					if (step < 4'd9) begin
						step <= step + 4'd1;
					end
					if (step == 4'd0) begin
						icap_cs_n <= 1'b1;
					end
					if (step == 4'd1) begin
						icap_wr_n <= 1'b0;
					end
					if (step == 4'd2) begin
						icap_din  <= byte_bitswap(OP_NOP);
						icap_cs_n <= 1'b0;
					end
					// CMD write, one word, desync
					if (step == 4'd4) begin
						icap_din <= byte_bitswap(OP_WRITE_CMD_HDR);
					end
					if (step == 4'd5) begin
						icap_din <= byte_bitswap(OP_DESYNC_CMD);
					end
					if (step == 4'd6) begin
						icap_din <= byte_bitswap(OP_NOP);
					end
					// trailing nops, then release the port
					if (step == 4'd8) begin
						icap_cs_n <= 1'b1;
						icap_wr_n <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

/* icap_model.sv */
`timescale 1ns/10ps

module icap_model #(
	parameter logic [31:0] IDCODE_VALUE = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cs_n,
	input  logic        wr_n,
	input  logic [31:0] din,
	output logic [31:0] dout
);

	import devinfo_pkg::*;

	localparam logic [2:0] LAT = 3'(ICAP_READ_LATENCY);

	// din with the byte swap undone
	logic [31:0] word;
	logic        wr_accept;
	logic        rd_sel;
	// config logic state
	logic        synced;
	logic [1:0]  skip_cnt;
	logic        cmd_pend;
	logic        rd_pend;
	logic [2:0]  lat_cnt;

	assign word      = byte_bitswap(din);
	assign wr_accept = !cs_n && !wr_n;
	assign rd_sel    = !cs_n && wr_n;

	////////////////////
	// write path, packet decode

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			synced   <= 1'b0;
			skip_cnt <= 2'd0;
			cmd_pend <= 1'b0;
			rd_pend  <= 1'b0;
		end else if (wr_accept) begin
			if (!synced) begin
				// everything before the sync word is dropped
				if (word == OP_SYNC) begin
					synced   <= 1'b1;
					skip_cnt <= 2'd2;
				end
			end else if (skip_cnt != 2'd0) begin
				// hazard slots after sync
				skip_cnt <= skip_cnt - 2'd1;
			end else if (cmd_pend) begin
				// data word of a CMD register write
				cmd_pend <= 1'b0;
				if (word == OP_DESYNC_CMD) begin
					synced <= 1'b0;
				end
			end else begin
				case (word)
					OP_READ_IDCODE_HDR: rd_pend <= 1'b1;
					OP_WRITE_CMD_HDR: begin
						cmd_pend <= 1'b1;
						rd_pend  <= 1'b0;
					end
					// nops and unsupported headers
					default: begin
					end
				endcase
			end
		end
	end

	////////////////////
	// read path, fixed pipeline delay

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lat_cnt <= 3'd0;
			dout    <= '1;
		end else if (rd_sel) begin
			if (lat_cnt != LAT) begin
				lat_cnt <= lat_cnt + 3'd1;
			end
			// held as long as cs stays low
			if (lat_cnt >= LAT - 3'd1 && synced && rd_pend) begin
				dout <= byte_bitswap(IDCODE_VALUE);
			end else begin
				dout <= '1;
			end
		end else begin
			// idle bus floats high
			lat_cnt <= 3'd0;
			dout    <= '1;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the device info testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module tb_device_info \
	-f all.f --Mdir obj_dir -o sim_device_info
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_device_info > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the log decides pass or fail
if grep -q "Something failed" sim.log; then
	exit 1
fi
exit 0

/* tb_device_info.sv */
`timescale 1ns/10ps

module tb_device_info;

	////////////////////
	// DUT settings

	localparam logic [23:0] BOOT_CYCLES  = 24'd40;
	// serial as written
	// only the low 57 bits exist on the die
	localparam logic [63:0] DNA_WORD     = 64'h0eadbeefc0def00d;
	localparam logic [31:0] IDCODE_VALUE = 32'h0364c093;

	// register map byte offsets
	localparam logic [11:0] ADDR_STATUS    = 12'h000;
	localparam logic [11:0] ADDR_SERIAL_LO = 12'h004;
	localparam logic [11:0] ADDR_SERIAL_HI = 12'h008;
	localparam logic [11:0] ADDR_IDCODE    = 12'h00c;

	// serial splits into 32 low bits and 25 high bits zero-extended
	localparam logic [31:0] EXP_SERIAL_LO = DNA_WORD[31:0];
	localparam logic [31:0] EXP_SERIAL_HI = {7'd0, DNA_WORD[56:32]};
	localparam int          N_ROWS        = 17;
	// boot 40, dna ~60, icap ~30, ~4 per transfer, 100 idle plus margin
	localparam int          MAX_CYCLES    = 2000;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	logic [31:0] lfsr_state = 32'hfd4154d4;

	// table columns are address, write flag, write data or expected prdata, expected pslverr
	logic [11:0] tbl_addr [N_ROWS];
	logic        tbl_wr   [N_ROWS];
	logic [31:0] tbl_data [N_ROWS];
	logic        tbl_err  [N_ROWS];
	int          n_rows = 0;

	device_info_top #(
		.BOOT_CYCLES (BOOT_CYCLES),
		.DNA_VALUE   (DNA_WORD[56:0]),
		.IDCODE_VALUE(IDCODE_VALUE)
	) uut (
		.clk    (clk),
		.rst_n  (rst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("run stopped at cycle %0d before the tests completed", cycle_cnt);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////
	// helpers

	// taps x^32 + x^22 + x^2 + x + 1
	// one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// anything from 0x10 up is unmapped
	task automatic random_unmapped(output logic [11:0] addr);
		logic [31:0] rnd;
		random_bits(12, rnd);
		addr = rnd[11:0];
		if (addr < 12'h010) begin
			addr = addr | 12'h010;
		end
	endtask

	task automatic check_word(input string name, input logic [11:0] addr,
			input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s at %h: got %h, expected %h", name, addr, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic [11:0] addr,
			input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s at %h: got %h, expected %h", name, addr, got, exp);
		end
	endtask

	// setup then access phase until pready
	task automatic apb_xfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready && wait_cnt < 16) begin
			@(negedge clk);
			wait_cnt++;
		end
		checks++;
		assert (pready) else begin
			errors++;
			$display("APB transfer to %h got no pready within 16 cycles", addr);
		end
		// sample mid-cycle away from the edge
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic add_row(input logic [11:0] addr, input logic wr,
			input logic [31:0] data, input logic err);
		tbl_addr[n_rows] = addr;
		tbl_wr[n_rows]   = wr;
		tbl_data[n_rows] = data;
		tbl_err[n_rows]  = err;
		n_rows++;
	endtask

	task automatic fill_table();
		logic [31:0] rnd;
		logic [11:0] bad;
		// mapped reads after both readers are done
		add_row(ADDR_STATUS, 1'b0, 32'h3, 1'b0);
		add_row(ADDR_SERIAL_LO, 1'b0, EXP_SERIAL_LO, 1'b0);
		add_row(ADDR_SERIAL_HI, 1'b0, EXP_SERIAL_HI, 1'b0);
		add_row(ADDR_IDCODE, 1'b0, IDCODE_VALUE, 1'b0);
		// every write to the read-only block errors
		for (int i = 0; i < 4; i++) begin
			random_bits(32, rnd);
			add_row(12'(i * 4), 1'b1, rnd, 1'b1);
		end
		for (int i = 0; i < 4; i++) begin
			random_unmapped(bad);
			add_row(bad, 1'b0, 32'd0, 1'b1);
		end
		random_unmapped(bad);
		random_bits(32, rnd);
		add_row(bad, 1'b1, rnd, 1'b1);
		// contents survive the rejected writes
		add_row(ADDR_STATUS, 1'b0, 32'h3, 1'b0);
		add_row(ADDR_SERIAL_LO, 1'b0, EXP_SERIAL_LO, 1'b0);
		add_row(ADDR_SERIAL_HI, 1'b0, EXP_SERIAL_HI, 1'b0);
		add_row(ADDR_IDCODE, 1'b0, IDCODE_VALUE, 1'b0);
	endtask

	////////////////////
	// test sequence

	initial begin : stimulus
		logic [31:0] rdata;
		logic        err;
		logic [31:0] status;
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= 12'd0;
		pwdata  <= 32'd0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// boot still running so all four registers read zero
		for (int i = 0; i < 4; i++) begin
			apb_xfer(12'(i * 4), 1'b0, 32'd0, rdata, err);
			check_word("prdata", 12'(i * 4), rdata, 32'd0);
			check_flag("pslverr", 12'(i * 4), err, 1'b0);
		end

		// poll until both valid bits are up within the watchdog limit
		status = 32'd0;
		while (status[1:0] != 2'b11) begin
			apb_xfer(ADDR_STATUS, 1'b0, 32'd0, status, err);
		end
		$display("both readers done by cycle %0d", cycle_cnt);

		fill_table();
		for (int row = 0; row < n_rows; row++) begin
			// reads drive zero on pwdata
			apb_xfer(tbl_addr[row], tbl_wr[row], tbl_wr[row] ? tbl_data[row] : 32'd0,
				rdata, err);
			check_flag("pslverr", tbl_addr[row], err, tbl_err[row]);
			// prdata only means something on a good read
			if (!tbl_wr[row] && !tbl_err[row]) begin
				check_word("prdata", tbl_addr[row], rdata, tbl_data[row]);
			end
		end

		// idcode must not drift after the desync
		repeat (100) @(posedge clk);
		apb_xfer(ADDR_IDCODE, 1'b0, 32'd0, rdata, err);
		check_word("prdata", ADDR_IDCODE, rdata, IDCODE_VALUE);
		check_flag("pslverr", ADDR_IDCODE, err, 1'b0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
